// ==== verilog.f ====
+incdir+hdl
hdl/cfu_pkg.sv
hdl/dp_ram.sv
hdl/cmd_fsm.sv
hdl/exec_sequencer.sv
hdl/cfu_top.sv
verif/tb_cfu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CFU testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_cfu -f verilog.f -o Vtb_cfu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_cfu > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Test failures found" "$log"; then
  echo "Simulation FAILED, see $log"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== verif/tb_cfu.sv ====
`timescale 1ns/1ps
`include "cfu_defines.svh"

module tb_cfu;

  // Limit on the whole run in clock cycles
  localparam int max_cycles = 20000;

  logic                      clk;
  logic                      resetn;
  logic                      cmd_valid;
  logic                      cmd_ready;
  logic [`CFU_FID_WIDTH-1:0] cmd_function_id;
  logic [`CFU_XLEN-1:0]      cmd_inputs_0;
  logic [`CFU_XLEN-1:0]      cmd_inputs_1;
  logic                      rsp_valid;
  logic                      rsp_ready;
  logic [`CFU_XLEN-1:0]      rsp_outputs_0;

  int cycle_count = 0;

  // Reference contents of both RAMs
  logic [`CFU_IWIDTH-1:0] instr_model [`CFU_NUM_WORDS];
  logic [`CFU_DWIDTH-1:0] data_model [`CFU_NUM_WORDS];

  cfu_top cfu_top_inst (
    .clk             (clk),
    .resetn          (resetn),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_outputs_0   (rsp_outputs_0)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      stop_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error: %s expected %h, got %h", name, expected, actual);
      stop_run();
    end
  endtask

  // One command entered and left on a falling edge
  task automatic run_cmd(input logic [6:0] funct7, input cfu_pkg::cfu_op_e op,
                         input logic [31:0] in0, input logic [31:0] in1,
                         output logic [31:0] result);
    int edges;
    int latency;
    // RAM reads take one edge more
    latency = (op == cfu_pkg::op_rd_instr || op == cfu_pkg::op_rd_data) ? 3 : 2;
    check_value("cmd_ready", 32'd1, 32'(cmd_ready));
    cmd_valid       = 1'b1;
    cmd_function_id = {funct7, op};
    cmd_inputs_0    = in0;
    cmd_inputs_1    = in1;
    rsp_ready       = 1'($urandom_range(0, 1));
    // Accepting edge
    @(negedge clk);
    cmd_valid = 1'b0;
    edges     = 0;
    while (!rsp_valid) begin
      check_value("cmd_ready", 32'd0, 32'(cmd_ready));
      @(negedge clk);
      edges++;
    end
    check_value("rsp_latency", 32'(latency), 32'(edges));
    check_value("cmd_ready", 32'd1, 32'(cmd_ready));
    result = rsp_outputs_0;
    // Response is a single-cycle pulse
    @(negedge clk);
    check_value("rsp_valid", 32'd0, 32'(rsp_valid));
  endtask

  task automatic expect_cmd(input logic [6:0] funct7, input cfu_pkg::cfu_op_e op,
                            input logic [31:0] in0, input logic [31:0] in1,
                            input logic [31:0] expected);
    logic [31:0] result;
    run_cmd(funct7, op, in0, in1, result);
    check_value("rsp_outputs_0", expected, result);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] done_word;
    logic [7:0]  hi;
    logic [8:0]  addr;
    void'($urandom(32'hdaf6));
    resetn          = 1'b0;
    cmd_valid       = 1'b0;
    cmd_function_id = '0;
    cmd_inputs_0    = '0;
    cmd_inputs_1    = '0;
    rsp_ready       = 1'b0;
    repeat (10) @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);

    // Idle after reset with the done flag clear
    check_value("cmd_ready", 32'd1, 32'(cmd_ready));
    check_value("rsp_valid", 32'd0, 32'(rsp_valid));
    expect_cmd(7'd1, cfu_pkg::op_exec, '0, '0, 32'd0);
    expect_cmd(7'd3, cfu_pkg::op_exec, '0, '0, 32'd0);

    // Byte sum keeps the carry in bit 8
    for (int i = 0; i < 32; i++) begin
      a = $urandom;
      b = $urandom;
      expect_cmd(7'd0, cfu_pkg::op_byte_sum, a, b, 32'(a[7:0]) + 32'(b[7:0]));
    end

    // Instruction RAM writes and read back
    for (int i = 16; i < 32; i++) begin
      instr_model[i] = $urandom;
      expect_cmd(7'd0, cfu_pkg::op_wr_instr, 32'(i), instr_model[i], '1);
    end
    for (int i = 16; i < 32; i++) begin
      expect_cmd(7'd0, cfu_pkg::op_rd_instr, 32'(i), $urandom, instr_model[i]);
    end

    // Data RAM writes
    // Address bit 8 shares in1 bit 8 with the high byte, so keep it even
    for (int i = 16; i < 32; i++) begin
      addr          = 9'(i);
      a             = $urandom;
      hi            = 8'($urandom) & 8'hfe;
      data_model[i] = {hi, a};
      b             = {16'($urandom), hi, addr[7:0]};
      expect_cmd(7'd0, cfu_pkg::op_wr_data, a, b, '1);
    end
    for (int i = 16; i < 32; i++) begin
      expect_cmd(7'd0, cfu_pkg::op_rd_data, 32'(i), '0, data_model[i][31:0]);
      expect_cmd(7'd1, cfu_pkg::op_rd_data, 32'(i), '0, 32'(data_model[i][39:32]));
    end

    // New words for the range 20..27 and the copy run
    for (int i = 20; i < 28; i++) begin
      instr_model[i] = $urandom;
      expect_cmd(7'd0, cfu_pkg::op_wr_instr, 32'(i), instr_model[i], '1);
    end
    expect_cmd(7'd2, cfu_pkg::op_exec, 32'd20, 32'd27, '1);
    expect_cmd(7'd0, cfu_pkg::op_exec, '0, '0, '1);
    done_word = '0;
    while (done_word !== 32'd1) begin
      run_cmd(7'd1, cfu_pkg::op_exec, '0, '0, done_word);
      if (done_word !== 32'd1) begin
        check_value("rsp_outputs_0", 32'd0, done_word);
      end
    end
    for (int i = 20; i < 28; i++) begin
      data_model[i] = {8'h00, instr_model[i]};
    end
    // Copied words inside the range and earlier data outside it
    for (int i = 16; i < 32; i++) begin
      expect_cmd(7'd0, cfu_pkg::op_rd_data, 32'(i), '0, data_model[i][31:0]);
      expect_cmd(7'd1, cfu_pkg::op_rd_data, 32'(i), '0, 32'(data_model[i][39:32]));
    end

    // Soft reset still answers with the sum and then clears done
    a = $urandom;
    b = $urandom;
    expect_cmd(7'd1, cfu_pkg::op_byte_sum, a, b, 32'(a[7:0]) + 32'(b[7:0]));
    expect_cmd(7'd1, cfu_pkg::op_exec, '0, '0, 32'd0);

    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== hdl/cfu_top.sv ====
`timescale 1ns/1ps
`include "cfu_defines.svh"

module cfu_top (
  input  logic                      clk,
  input  logic                      resetn,
  // Command channel
  input  logic                      cmd_valid,
  output logic                      cmd_ready,
  input  logic [`CFU_FID_WIDTH-1:0] cmd_function_id,
  input  logic [`CFU_XLEN-1:0]      cmd_inputs_0,
  input  logic [`CFU_XLEN-1:0]      cmd_inputs_1,
  // Response channel
  // rsp_ready has no effect, the response is a one-cycle pulse
  output logic                      rsp_valid,
  input  logic                      rsp_ready,
  output logic [`CFU_XLEN-1:0]      rsp_outputs_0
);

  // Instruction RAM, CPU side
  logic                 instr_we;
  cfu_pkg::ram_addr_t   instr_addr;
  cfu_pkg::instr_word_t instr_wdata;
  cfu_pkg::instr_word_t instr_rdata;

  // Instruction RAM, sequencer side
  cfu_pkg::ram_addr_t   instr_rd_addr;
  cfu_pkg::instr_word_t exec_rdata;

  // Data RAM
  cfu_pkg::ram_addr_t   data_rd_addr;
  cfu_pkg::data_word_t  data_rdata;
  cfu_pkg::data_wr_t    data_wr_req;
  cfu_pkg::data_wr_t    data_wr;

  // Sequencer control
  cfu_pkg::exec_range_t exec_range;
  logic                 exec_start;
  logic                 exec_resetn;
  logic                 exec_done;

  cmd_fsm u_cmd_fsm (
    .clk             (clk),
    .resetn          (resetn),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_outputs_0   (rsp_outputs_0),
    .instr_we        (instr_we),
    .instr_addr      (instr_addr),
    .instr_wdata     (instr_wdata),
    .instr_rdata     (instr_rdata),
    .data_rd_addr    (data_rd_addr),
    .data_rdata      (data_rdata),
    .data_wr_req     (data_wr_req),
    .exec_range      (exec_range),
    .exec_start      (exec_start),
    .exec_resetn     (exec_resetn),
    .exec_done       (exec_done)
  );

  // Runs on the soft reset, which also covers the hard reset
  exec_sequencer u_exec_sequencer (
    .clk           (clk),
    .resetn        (exec_resetn),
    .exec_range    (exec_range),
    .exec_start    (exec_start),
    .exec_done     (exec_done),
    .instr_rd_addr (instr_rd_addr),
    .instr_rdata   (exec_rdata),
    .cpu_wr        (data_wr_req),
    .data_wr       (data_wr)
  );

  // Port A for CPU access, port B read by the sequencer
  dp_ram #(.word_t(cfu_pkg::instr_word_t)) u_instr_ram (
    .clk     (clk),
    .a_addr  (instr_addr),
    .a_we    (instr_we),
    .a_wdata (instr_wdata),
    .a_rdata (instr_rdata),
    .b_addr  (instr_rd_addr),
    .b_we    (1'b0),
    .b_wdata ('0),
    .b_rdata (exec_rdata)
  );

  // Port A writes only, port B serves op6 reads
  dp_ram #(.word_t(cfu_pkg::data_word_t)) u_data_ram (
    .clk     (clk),
    .a_addr  (data_wr.addr),
    .a_we    (data_wr.we),
    .a_wdata (data_wr.wdata),
    .a_rdata (),
    .b_addr  (data_rd_addr),
    .b_we    (1'b0),
    .b_wdata ('0),
    .b_rdata (data_rdata)
  );

endmodule

// ==== hdl/exec_sequencer.sv ====
`timescale 1ns/1ps
`include "cfu_defines.svh"

module exec_sequencer (
  input  logic                  clk,
  input  logic                  resetn,
  // Control from the command FSM
  input  cfu_pkg::exec_range_t  exec_range,
  input  logic                  exec_start,
  output logic                  exec_done,
  // Instruction RAM port B, read only
  output cfu_pkg::ram_addr_t    instr_rd_addr,
  input  cfu_pkg::instr_word_t  instr_rdata,
  // Data RAM port A
  input  cfu_pkg::data_wr_t     cpu_wr,
  output cfu_pkg::data_wr_t     data_wr
);

  cfu_pkg::exec_range_t range_q;
  cfu_pkg::ram_addr_t   wr_addr_q;    // address of the word now on instr_rdata
  cfu_pkg::data_wr_t    seq_wr;
  logic                 issuing;      // reads still being issued
  logic                 rd_valid_q;   // instr_rdata holds a word to write
  logic                 rd_last_q;    // and it is the end of the range
  logic                 busy;
  logic                 launch;

  // Busy from launch until the last write is out
  assign busy   = issuing | rd_valid_q;
  // A start while busy is dropped
  assign launch = exec_start & ~busy;

  ////////////////////////////////////////////////////////////////////////////
  // Run control and done flag
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      issuing    <= 1'b0;
      rd_valid_q <= 1'b0;
      exec_done  <= 1'b0;
    end else begin
      // Every issued read returns one cycle later
      rd_valid_q <= issuing;
      if (launch) begin
        issuing   <= 1'b1;
        exec_done <= 1'b0;
      end else if (issuing && (instr_rd_addr == range_q.end_addr)) begin
        // Last read issued
        issuing <= 1'b0;
      end
      // Set on the edge that writes end_addr
      if (rd_valid_q && rd_last_q) begin
        exec_done <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address walk
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (launch) begin
      range_q       <= exec_range;
      instr_rd_addr <= exec_range.start_addr;
    end else if (issuing) begin
      // Wraps at the RAM depth if end is below start
      instr_rd_addr <= instr_rd_addr + 1'b1;
    end
    // Track the address alongside the registered read
    wr_addr_q <= instr_rd_addr;
    rd_last_q <= (instr_rd_addr == range_q.end_addr);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data RAM write port
  ////////////////////////////////////////////////////////////////////////////

  // Copy the instruction word to the same address, zero-extended
  assign seq_wr.we    = rd_valid_q;
  assign seq_wr.addr  = wr_addr_q;
  assign seq_wr.wdata = {{(`CFU_DWIDTH-`CFU_IWIDTH){1'b0}}, instr_rdata};

  // Sequencer owns the port while busy, CPU writes in that window are lost
  assign data_wr = busy ? seq_wr : cpu_wr;

endmodule

// ==== hdl/cmd_fsm.sv ====
`timescale 1ns/1ps
`include "cfu_defines.svh"

module cmd_fsm (
  input  logic                      clk,
  input  logic                      resetn,
  // Command channel
  input  logic                      cmd_valid,
  output logic                      cmd_ready,
  input  logic [`CFU_FID_WIDTH-1:0] cmd_function_id,
  input  logic [`CFU_XLEN-1:0]      cmd_inputs_0,
  input  logic [`CFU_XLEN-1:0]      cmd_inputs_1,
  // Response channel
  output logic                      rsp_valid,
  output logic [`CFU_XLEN-1:0]      rsp_outputs_0,
  // Instruction RAM port A
  output logic                      instr_we,
  output cfu_pkg::ram_addr_t        instr_addr,
  output cfu_pkg::instr_word_t      instr_wdata,
  input  cfu_pkg::instr_word_t      instr_rdata,
  // Data RAM read port B
  output cfu_pkg::ram_addr_t        data_rd_addr,
  input  cfu_pkg::data_word_t       data_rdata,
  // Op5 write request, arbitrated in the sequencer
  output cfu_pkg::data_wr_t         data_wr_req,
  // Sequencer control
  output cfu_pkg::exec_range_t      exec_range,
  output logic                      exec_start,
  output logic                      exec_resetn,
  input  logic                      exec_done
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_respond
  } state_e;

  state_e                    state;
  cfu_pkg::cmd_t             cmd_q;
  logic                      accept;
  logic                      issue;      // first cycle after acceptance
  logic                      slow;       // extra wait cycle still owed
  logic [`CFU_FID_WIDTH-4:0] funct7_in;
  cfu_pkg::cfu_op_e          funct3_in;
  logic                      two_cycle_in;
  logic [8:0]                byte_sum;
  logic [`CFU_XLEN-1:0]      rsp_sel;

  ////////////////////////////////////////////////////////////////////////////
  // Incoming command decode
  ////////////////////////////////////////////////////////////////////////////

  // funct7 sits above funct3 in the function id
  assign funct7_in = cmd_function_id[`CFU_FID_WIDTH-1:3];
  assign funct3_in = cfu_pkg::cfu_op_e'(cmd_function_id[2:0]);

  // cmd_ready is only high in idle, so this is also the idle exit
  assign accept = cmd_valid & cmd_ready;

  // RAM reads need the extra cycle
  assign two_cycle_in = (funct3_in == cfu_pkg::op_rd_instr) ||
                        (funct3_in == cfu_pkg::op_rd_data);

  ////////////////////////////////////////////////////////////////////////////
  // Handshake state machine
  ////////////////////////////////////////////////////////////////////////////

  // idle -> wait (1 or 2 cycles) -> respond -> idle
  // rsp_valid and cmd_ready rise together on the respond exit
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= st_idle;
      cmd_ready <= 1'b1;
      rsp_valid <= 1'b0;
      issue     <= 1'b0;
      slow      <= 1'b0;
    end else begin
      issue     <= accept;
      // Single-cycle pulse, rsp_ready is not looked at
      rsp_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            state     <= st_wait;
            cmd_ready <= 1'b0;
            slow      <= two_cycle_in;
          end
        end
        st_wait: begin
          if (slow) begin
            slow <= 1'b0;
          end else begin
            state <= st_respond;
          end
        end
        st_respond: begin
          state     <= st_idle;
          rsp_valid <= 1'b1;
          cmd_ready <= 1'b1;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Capture the command
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q.funct7 <= funct7_in;
      cmd_q.funct3 <= funct3_in;
      cmd_q.in0    <= cmd_inputs_0;
      cmd_q.in1    <= cmd_inputs_1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // RAM and sequencer strobes, one cycle after acceptance
  ////////////////////////////////////////////////////////////////////////////

  // Op3, instruction write
  assign instr_we    = issue && (cmd_q.funct3 == cfu_pkg::op_wr_instr);
  assign instr_addr  = cmd_q.in0[`CFU_AWIDTH-1:0];
  assign instr_wdata = cmd_q.in1;

  // Op6 read address, held until the response
  assign data_rd_addr = cmd_q.in0[`CFU_AWIDTH-1:0];

  // Op5 data write, high byte taken from in1[15:8]
  assign data_wr_req.we    = issue && (cmd_q.funct3 == cfu_pkg::op_wr_data);
  assign data_wr_req.addr  = cmd_q.in1[`CFU_AWIDTH-1:0];
  assign data_wr_req.wdata = {cmd_q.in1[15:8], cmd_q.in0};

  // Op7 funct7 0 launches the sequencer
  assign exec_start = issue && (cmd_q.funct3 == cfu_pkg::op_exec) && (cmd_q.funct7 == 7'd0);

  // Op7 funct7 2 loads the range: start in in0, end in in1
  always_ff @(posedge clk) begin
    if (!resetn) begin
      exec_range <= '0;
    end else if (issue && (cmd_q.funct3 == cfu_pkg::op_exec) && (cmd_q.funct7 == 7'd2)) begin
      exec_range.start_addr <= cmd_q.in0[`CFU_AWIDTH-1:0];
      exec_range.end_addr   <= cmd_q.in1[`CFU_AWIDTH-1:0];
    end
  end

  // Soft reset for the sequencer
  // Op0 with funct7 1 pulls it low, any other accepted command releases it
  // Low during hard reset too, so the sequencer sees both
  always_ff @(posedge clk) begin
    if (!resetn) begin
      exec_resetn <= 1'b0;
    end else if (accept) begin
      exec_resetn <= !((funct3_in == cfu_pkg::op_byte_sum) && (funct7_in == 7'd1));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response select
  ////////////////////////////////////////////////////////////////////////////

  // Low byte sum, 9 bits wide so the carry survives
  assign byte_sum = cmd_q.in0[7:0] + cmd_q.in1[7:0];

  always_comb begin
    // All ones unless something below claims the op
    rsp_sel = '1;
    case (cmd_q.funct3)
      cfu_pkg::op_byte_sum: begin
        rsp_sel = {{(`CFU_XLEN-9){1'b0}}, byte_sum};
      end
      cfu_pkg::op_rd_instr: begin
        rsp_sel = instr_rdata;
      end
      cfu_pkg::op_rd_data: begin
        // funct7 picks the low word or the extra byte
        if (cmd_q.funct7 == 7'd0) begin
          rsp_sel = data_rdata[`CFU_XLEN-1:0];
        end else if (cmd_q.funct7 == 7'd1) begin
          rsp_sel = {{(2*`CFU_XLEN-`CFU_DWIDTH){1'b0}},
                     data_rdata[`CFU_DWIDTH-1:`CFU_XLEN]};
        end
      end
      cfu_pkg::op_exec: begin
        if (cmd_q.funct7 == 7'd1) begin
          rsp_sel = {{(`CFU_XLEN-1){1'b0}}, exec_done};
        end else if (cmd_q.funct7 >= 7'd3) begin
          rsp_sel = '0;
        end
      end
      default: begin
      end
    endcase
  end

  // Response payload, sampled as respond exits
  always_ff @(posedge clk) begin
    if (state == st_respond) begin
      rsp_outputs_0 <= rsp_sel;
    end
  end

endmodule

// ==== hdl/dp_ram.sv ====
`timescale 1ns/1ps
`include "cfu_defines.svh"

// True dual-port RAM, one clock, word type chosen per instance
module dp_ram #(
  parameter type word_t = logic [31:0]
) (
  input  logic                   clk,
  // Port A
  input  logic [`CFU_AWIDTH-1:0] a_addr,
  input  logic                   a_we,
  input  word_t                  a_wdata,
  output word_t                  a_rdata,
  // Port B
  input  logic [`CFU_AWIDTH-1:0] b_addr,
  input  logic                   b_we,
  input  word_t                  b_wdata,
  output word_t                  b_rdata
);

  // Storage array
  word_t mem [`CFU_NUM_WORDS];

  // Both ports in one process
  // Reads are registered and return the old word on a same-address write
  // If both ports write one address, port B lands last
  always_ff @(posedge clk) begin
    if (a_we) begin
      mem[a_addr] <= a_wdata;
    end
    if (b_we) begin
      mem[b_addr] <= b_wdata;
    end
    a_rdata <= mem[a_addr];
    b_rdata <= mem[b_addr];
  end

endmodule

// ==== hdl/cfu_pkg.sv ====
`include "cfu_defines.svh"

package cfu_pkg;

  // Operation codes, carried in funct3 of the function id
  // Codes 1 and 2 are not decoded and fall to the default response
  typedef enum logic [2:0] {
    op_byte_sum = 3'd0,
    op_wr_instr = 3'd3,
    op_rd_instr = 3'd4,
    op_wr_data  = 3'd5,
    op_rd_data  = 3'd6,
    op_exec     = 3'd7
  } cfu_op_e;

  // Word and address types of the two RAMs
  typedef logic [`CFU_IWIDTH-1:0] instr_word_t;
  typedef logic [`CFU_DWIDTH-1:0] data_word_t;
  typedef logic [`CFU_AWIDTH-1:0] ram_addr_t;

  // Command as captured on the accepting edge
  typedef struct packed {
    logic [`CFU_FID_WIDTH-4:0] funct7;
    cfu_op_e                   funct3;
    logic [`CFU_XLEN-1:0]      in0;
    logic [`CFU_XLEN-1:0]      in1;
  } cmd_t;

  // Instruction range walked by the sequencer, both ends inclusive
  typedef struct packed {
    ram_addr_t start_addr;
    ram_addr_t end_addr;
  } exec_range_t;

  // One write into the data RAM
  typedef struct packed {
    logic       we;
    ram_addr_t  addr;
    data_word_t wdata;
  } data_wr_t;

endpackage

// ==== hdl/cfu_defines.svh ====
`ifndef CFU_DEFINES_SVH
`define CFU_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Memory geometry
////////////////////////////////////////////////////////////////////////////

// Address width shared by instruction and data RAMs
`define CFU_AWIDTH 9

// Depth of each RAM, 2**CFU_AWIDTH
`define CFU_NUM_WORDS 512

// Stored instruction word
`define CFU_IWIDTH 32

// Data RAM word, 32 bits from in0 plus one extra byte from in1
`define CFU_DWIDTH 40

////////////////////////////////////////////////////////////////////////////
// CPU side interface
////////////////////////////////////////////////////////////////////////////

// Operand and response width
`define CFU_XLEN 32

// Function id, funct7 in the upper bits and funct3 in the low three
`define CFU_FID_WIDTH 10

`endif
